// File: rtl/tlk2711_tx_settings.svh
//////////////////////////////
// tlk2711 tx framer constants
// code words, widths, depths and cycle counts
//////////////////////////////
`ifndef TLK2711_TX_SETTINGS_SVH
`define TLK2711_TX_SETTINGS_SVH

// data path widths
`define TX_DMA_W        64
`define TX_LINE_W       16

// fifo depth in dma words
`define TX_FIFO_DEPTH   64

// comma words before the first frame
`define TX_SYNC_CYCLES  6

// inter-frame gap in normal mode
`define TX_NORM_GAP     257

// line code words, msb byte over lsb byte
`define TX_IDLE_WORD    16'hC5BC
`define TX_SOF_WORD     16'h5CFB
`define TX_EOF_WORD     16'hFDFE

// frame header
`define TX_HEAD0        16'hEB90
`define TX_HEAD1        16'hE116

// file sign bytes
`define TX_IND          8'h81
`define TX_FILE_END     8'h01

`endif

// File: rtl/tlk2711_tx_pkg.sv
//////////////////////////////
// tlk2711 tx types
// mode codes, frame states and file sign layout
//////////////////////////////
`default_nettype none

package tlk2711_tx_pkg;

    // only these two codes send, the rest stay idle
    typedef enum logic [2:0] {
        NORM     = 3'd0,
        SPECIFIC = 3'd3
    } tx_mode_t;

    typedef enum logic [3:0] {
        IDLE, SYNC, SOF, HEAD0, HEAD1, FILE_SIGN, FRAME_NUM,
        LENGTH, DATA, CHECKSUM, EOF, GAP, INTR
    } tx_state_t;

    // normal mode view
    typedef struct packed {
        logic [7:0] type_byte;
        logic [7:0] end_byte;
    } file_sign_bytes_t;

    // specific mode view
    typedef struct packed {
        logic       rsvd_hi;
        logic       last_frame;
        logic       rsvd_lo;
        logic       channel_id;
        logic [3:0] sweep;
        logic [7:0] frame_hi;
    } file_sign_fields_t;

    typedef union packed {
        file_sign_bytes_t  bytes;
        file_sign_fields_t fields;
    } file_sign_t;

endpackage

`default_nettype wire

// File: rtl/tx_width_fifo.sv
//////////////////////////////
// tx width fifo
// 64-bit dma words in, 16-bit line words out, fwft
//////////////////////////////
`default_nettype none
`include "tlk2711_tx_settings.svh"

module tx_width_fifo (
    input  wire logic                 clk,
    input  wire logic                 i_soft_reset,
    input  wire logic                 i_wr,
    input  wire logic [`TX_DMA_W-1:0] i_wdata,
    input  wire logic                 i_rd,
    output logic [`TX_LINE_W-1:0]     o_rdata,
    output logic                      o_full,
    output logic                      o_empty,
    output logic [8:0]                o_level
);

    localparam int AW = $clog2(`TX_FIFO_DEPTH);

    logic [`TX_DMA_W-1:0] mem [`TX_FIFO_DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          count;
    logic [1:0]           lane;
    logic                 do_wr;
    logic                 do_rd;
    logic                 free_entry;

    assign do_wr      = i_wr && !o_full;
    assign do_rd      = i_rd && !o_empty;
    // entry goes back to the pool once its top lane is out
    assign free_entry = do_rd && (lane == 2'd3);

    assign o_full  = (count == `TX_FIFO_DEPTH);
    assign o_empty = (count == '0);
    // line words left, partly read entry included
    assign o_level = {count, 2'b00} - {{(AW + 1){1'b0}}, lane};
    // low lane first
    assign o_rdata = mem[rd_ptr][lane * `TX_LINE_W +: `TX_LINE_W];

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= i_wdata;
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            lane   <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                lane <= lane + 1'b1;
            if (free_entry)
                rd_ptr <= rd_ptr + 1'b1;

            case ({do_wr, free_entry})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/frame_sequencer.sv
//////////////////////////////
// frame sequencer
// frame fsm with sync, data, gap and interrupt counters
//////////////////////////////
`default_nettype none
`include "tlk2711_tx_settings.svh"

module frame_sequencer
    import tlk2711_tx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_soft_reset,
    input  wire tx_mode_t    i_mode,
    input  wire logic        i_armed,
    input  wire logic        i_fifo_empty,
    input  wire logic [8:0]  i_fifo_level,
    input  wire logic [15:0] i_packet_body,
    input  wire logic [15:0] i_packet_tail,
    input  wire logic [23:0] i_body_num,
    input  wire logic [19:0] i_backward_cycle_num,
    input  wire logic [15:0] i_intr_width,
    output tx_state_t        o_state,
    output logic             o_fifo_rd,
    output logic [23:0]      o_frame_num,
    output logic [15:0]      o_valid_len,
    output logic             o_last_frame,
    output logic             o_channel_id,
    output logic             o_tx_interrupt
);

    localparam int SYNC_W = $clog2(`TX_SYNC_CYCLES + 1);

    tx_state_t         state;
    tx_state_t         state_nxt;
    logic [SYNC_W-1:0] sync_cnt;
    logic [14:0]       data_cnt;
    logic [19:0]       gap_cnt;
    logic [15:0]       intr_cnt;
    logic [15:0]       next_len;
    logic [19:0]       gap_len;
    logic              mode_ok;
    logic              at_last;
    logic              level_ok;
    logic              sync_done;
    logic              data_done;
    logic              gap_done;
    logic              intr_done;

    assign mode_ok  = (i_mode == NORM) || (i_mode == SPECIFIC);
    assign at_last  = (o_frame_num == i_body_num);
    // tail frame carries the tail length
    assign next_len = at_last ? i_packet_tail : i_packet_body;
    // whole frame must already sit in the fifo
    assign level_ok = {7'd0, i_fifo_level} >= {1'b0, next_len[15:1]};
    assign gap_len  = (i_mode == SPECIFIC) ? i_backward_cycle_num : 20'(`TX_NORM_GAP);

    assign sync_done = (sync_cnt == SYNC_W'(`TX_SYNC_CYCLES - 1));
    assign data_done = ({1'b0, data_cnt} + 16'd1) >= {1'b0, o_valid_len[15:1]};
    assign gap_done  = ({1'b0, gap_cnt} + 21'd1) >= {1'b0, gap_len};
    assign intr_done = ({1'b0, intr_cnt} + 17'd1) >= {1'b0, i_intr_width};

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_armed && !i_fifo_empty && mode_ok)
                    state_nxt = SYNC;
            end
            SYNC: begin
                if (sync_done && level_ok)
                    state_nxt = SOF;
            end
            SOF:       state_nxt = HEAD0;
            HEAD0:     state_nxt = HEAD1;
            HEAD1:     state_nxt = FILE_SIGN;
            FILE_SIGN: state_nxt = FRAME_NUM;
            FRAME_NUM: state_nxt = LENGTH;
            // empty frame skips the data slot
            LENGTH:    state_nxt = (o_valid_len[15:1] == 15'd0) ? CHECKSUM : DATA;
            DATA: begin
                if (data_done)
                    state_nxt = CHECKSUM;
            end
            CHECKSUM:  state_nxt = EOF;
            EOF:       state_nxt = GAP;
            GAP: begin
                if (gap_done) begin
                    if (o_last_frame)
                        state_nxt = INTR;
                    else if (level_ok)
                        state_nxt = SOF;
                end
            end
            INTR: begin
                if (intr_done)
                    state_nxt = IDLE;
            end
            default:   state_nxt = IDLE;
        endcase
    end

    //////////////////////////////
    // state and counters
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state        <= IDLE;
            sync_cnt     <= '0;
            data_cnt     <= '0;
            gap_cnt      <= '0;
            intr_cnt     <= '0;
            o_frame_num  <= '0;
            o_valid_len  <= '0;
            o_last_frame <= 1'b0;
            o_channel_id <= 1'b0;
        end else begin
            state <= state_nxt;

            // sync and gap counters hold at the end while the fifo fills
            if (state != SYNC)
                sync_cnt <= '0;
            else if (!sync_done)
                sync_cnt <= sync_cnt + 1'b1;

            if (state != GAP)
                gap_cnt <= '0;
            else if (!gap_done)
                gap_cnt <= gap_cnt + 1'b1;

            data_cnt <= (state == DATA) ? data_cnt + 1'b1 : '0;
            intr_cnt <= (state == INTR) ? intr_cnt + 1'b1 : '0;

            if (state == SOF) begin
                o_valid_len  <= next_len;
                o_last_frame <= at_last;
            end

            // numbering restarts after the tail frame
            if (state == EOF)
                o_frame_num <= o_last_frame ? '0 : o_frame_num + 1'b1;

            if (state == FILE_SIGN && i_mode == SPECIFIC)
                o_channel_id <= ~o_channel_id;
        end
    end

    assign o_state        = state;
    assign o_fifo_rd      = (state == DATA);
    assign o_tx_interrupt = (state == INTR);

endmodule

`default_nettype wire

// File: rtl/tx_word_encoder.sv
//////////////////////////////
// tx word encoder
// line word select, checksum and serializer registers
//////////////////////////////
`default_nettype none
`include "tlk2711_tx_settings.svh"

module tx_word_encoder
    import tlk2711_tx_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        i_soft_reset,
    input  wire tx_mode_t    i_mode,
    input  wire tx_state_t   i_state,
    input  wire logic [23:0] i_frame_num,
    input  wire logic [15:0] i_valid_len,
    input  wire logic        i_last_frame,
    input  wire logic        i_channel_id,
    input  wire logic [15:0] i_fifo_data,
    output logic [15:0]      o_txd,
    output logic             o_tkmsb,
    output logic             o_tklsb
);

    file_sign_t  sign;
    logic [15:0] word_sel;
    logic        k_msb;
    logic        k_lsb;
    logic [15:0] checksum;

    // file sign word, one layout per mode
    always_comb begin
        sign = '0;
        if (i_mode == SPECIFIC) begin
            sign.fields.last_frame = i_last_frame;
            sign.fields.channel_id = i_channel_id;
            sign.fields.sweep      = 4'h1;
            sign.fields.frame_hi   = i_frame_num[23:16];
        end else begin
            sign.bytes.type_byte = `TX_IND;
            sign.bytes.end_byte  = i_last_frame ? `TX_FILE_END : 8'h00;
        end
    end

    //////////////////////////////
    // word select
    //////////////////////////////
    always_comb begin
        word_sel = `TX_IDLE_WORD;
        k_msb    = 1'b0;
        k_lsb    = 1'b0;
        case (i_state)
            SOF: begin
                word_sel = `TX_SOF_WORD;
                k_msb    = 1'b1;
                k_lsb    = 1'b1;
            end
            HEAD0:     word_sel = `TX_HEAD0;
            HEAD1:     word_sel = `TX_HEAD1;
            FILE_SIGN: word_sel = sign;
            FRAME_NUM: word_sel = i_frame_num[15:0];
            LENGTH:    word_sel = i_valid_len;
            DATA:      word_sel = i_fifo_data;
            CHECKSUM:  word_sel = checksum;
            EOF: begin
                word_sel = `TX_EOF_WORD;
                k_msb    = 1'b1;
                k_lsb    = 1'b1;
            end
            // idle, sync, gap and interrupt send commas
            default: begin
                word_sel = `TX_IDLE_WORD;
                k_lsb    = 1'b1;
            end
        endcase
    end

    // sum of frame number, length and data words
    always_ff @(posedge clk) begin
        if (i_soft_reset || i_state == SOF)
            checksum <= '0;
        else if (i_state inside {FRAME_NUM, LENGTH, DATA})
            checksum <= checksum + word_sel;
    end

    // one cycle behind the state
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_txd   <= `TX_IDLE_WORD;
            o_tkmsb <= 1'b0;
            o_tklsb <= 1'b1;
        end else begin
            o_txd   <= word_sel;
            o_tkmsb <= k_msb;
            o_tklsb <= k_lsb;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tlk2711_tx_top.sv
//////////////////////////////
// tlk2711 tx framer top
// start detect, mode latch, status and block wiring
//////////////////////////////
`default_nettype none
`include "tlk2711_tx_settings.svh"

module tlk2711_tx_top
    import tlk2711_tx_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 i_soft_reset,
    input  wire logic [2:0]           i_tx_mode,
    input  wire logic                 i_tx_start,
    input  wire logic [15:0]          i_tx_packet_body,
    input  wire logic [15:0]          i_tx_packet_tail,
    input  wire logic [23:0]          i_tx_body_num,
    input  wire logic [15:0]          i_tx_intr_width,
    input  wire logic [19:0]          i_backward_cycle_num,
    input  wire logic                 i_dma_rd_valid,
    input  wire logic [`TX_DMA_W-1:0] i_dma_rd_data,
    output logic                      o_dma_rd_ready,
    output logic                      o_tx_interrupt,
    output logic [8:0]                o_tx_status,
    output logic [15:0]               o_2711_txd,
    output logic                      o_2711_tkmsb,
    output logic                      o_2711_tklsb
);

    logic        start_d1;
    logic        start_d2;
    logic        start_pulse;
    logic        armed;
    tx_mode_t    mode;
    tx_state_t   seq_state;
    logic        fifo_wr;
    logic        fifo_rd;
    logic        fifo_full;
    logic        fifo_empty;
    logic [8:0]  fifo_level;
    logic [15:0] fifo_rdata;
    logic [23:0] frame_num;
    logic [15:0] valid_len;
    logic        last_frame;
    logic        channel_id;

    //////////////////////////////
    // start and mode
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            start_d1    <= 1'b0;
            start_d2    <= 1'b0;
            start_pulse <= 1'b0;
            mode        <= NORM;
            armed       <= 1'b0;
        end else begin
            start_d1    <= i_tx_start;
            start_d2    <= start_d1;
            start_pulse <= start_d1 && !start_d2;
            if (start_pulse)
                mode <= tx_mode_t'(i_tx_mode);
            // one send per start, dropped once the first gap begins
            if (start_pulse)
                armed <= 1'b1;
            else if (seq_state == GAP)
                armed <= 1'b0;
        end
    end

    assign o_dma_rd_ready = !fifo_full;
    assign fifo_wr        = i_dma_rd_valid && o_dma_rd_ready;
    assign o_tx_status    = {fifo_empty, fifo_full, seq_state, mode};

    tx_width_fifo u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_wr         (fifo_wr),
        .i_wdata      (i_dma_rd_data),
        .i_rd         (fifo_rd),
        .o_rdata      (fifo_rdata),
        .o_full       (fifo_full),
        .o_empty      (fifo_empty),
        .o_level      (fifo_level)
    );

    frame_sequencer u_seq (
        .clk                  (clk),
        .i_soft_reset         (i_soft_reset),
        .i_mode               (mode),
        .i_armed              (armed),
        .i_fifo_empty         (fifo_empty),
        .i_fifo_level         (fifo_level),
        .i_packet_body        (i_tx_packet_body),
        .i_packet_tail        (i_tx_packet_tail),
        .i_body_num           (i_tx_body_num),
        .i_backward_cycle_num (i_backward_cycle_num),
        .i_intr_width         (i_tx_intr_width),
        .o_state              (seq_state),
        .o_fifo_rd            (fifo_rd),
        .o_frame_num          (frame_num),
        .o_valid_len          (valid_len),
        .o_last_frame         (last_frame),
        .o_channel_id         (channel_id),
        .o_tx_interrupt       (o_tx_interrupt)
    );

    tx_word_encoder u_enc (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_mode       (mode),
        .i_state      (seq_state),
        .i_frame_num  (frame_num),
        .i_valid_len  (valid_len),
        .i_last_frame (last_frame),
        .i_channel_id (channel_id),
        .i_fifo_data  (fifo_rdata),
        .o_txd        (o_2711_txd),
        .o_tkmsb      (o_2711_tkmsb),
        .o_tklsb      (o_2711_tklsb)
    );

endmodule

`default_nettype wire

// File: test/tlk2711_tx_chk.sv
//////////////////////////////
// tlk2711 tx line checker
// k-flag and interrupt rules on the serializer outputs
//////////////////////////////
`default_nettype none
`include "tlk2711_tx_settings.svh"

module tlk2711_tx_chk
    import tlk2711_tx_pkg::*;
(
    input wire logic        clk,
    input wire logic        i_soft_reset,
    input wire tx_state_t   i_state,
    input wire logic [15:0] i_txd,
    input wire logic        i_tkmsb,
    input wire logic        i_tklsb,
    input wire logic        i_tx_interrupt
);
    timeunit 1ns;
    timeprecision 100ps;

    // both flags only on the frame delimiters
    k_pair_on_marks: assert property (@(posedge clk) disable iff (i_soft_reset)
        (i_tkmsb && i_tklsb) |-> (i_txd == `TX_SOF_WORD || i_txd == `TX_EOF_WORD))
        else $error("k-flag pair on word %h", i_txd);

    // lsb flag alone means a comma
    comma_flag: assert property (@(posedge clk) disable iff (i_soft_reset)
        (i_tklsb && !i_tkmsb) |-> (i_txd == `TX_IDLE_WORD))
        else $error("comma flag on word %h", i_txd);

    // interrupt window only opens after the last gap
    irq_after_gap: assert property (@(posedge clk) disable iff (i_soft_reset)
        i_tx_interrupt |-> ($past(i_state) == GAP || $past(i_state) == INTR))
        else $error("interrupt raised without a preceding gap");

    reset_comma: assert property (@(posedge clk)
        i_soft_reset |=> (i_txd == `TX_IDLE_WORD && i_tklsb && !i_tkmsb))
        else $error("line not at comma after reset");

endmodule

bind tlk2711_tx_top tlk2711_tx_chk chk0 (
    .clk            (clk),
    .i_soft_reset   (i_soft_reset),
    .i_state        (seq_state),
    .i_txd          (o_2711_txd),
    .i_tkmsb        (o_2711_tkmsb),
    .i_tklsb        (o_2711_tklsb),
    .i_tx_interrupt (o_tx_interrupt)
);

`default_nettype wire

// File: test/tb_tlk2711_tx.sv
//////////////////////////////
// tlk2711 tx framer testbench
// table driven sends checked against a frame model
//////////////////////////////
`default_nettype none
`include "tlk2711_tx_settings.svh"

module tb_tlk2711_tx
    import tlk2711_tx_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS = 4;

    logic        clk;
    logic        i_soft_reset;
    logic [2:0]  i_tx_mode;
    logic        i_tx_start;
    logic [15:0] i_tx_packet_body;
    logic [15:0] i_tx_packet_tail;
    logic [23:0] i_tx_body_num;
    logic [15:0] i_tx_intr_width;
    logic [19:0] i_backward_cycle_num;
    logic        i_dma_rd_valid = 1'b0;
    logic [63:0] i_dma_rd_data = '0;
    logic        o_dma_rd_ready;
    logic        o_tx_interrupt;
    logic [8:0]  o_tx_status;
    logic [15:0] o_2711_txd;
    logic        o_2711_tkmsb;
    logic        o_2711_tklsb;

    // mode, body bytes, tail bytes, body count, gap, interrupt width, fill fifo first
    tx_mode_t tab_mode [ROWS] = '{NORM, SPECIFIC, NORM, SPECIFIC};
    int       tab_body [ROWS] = '{64, 128, 512, 40};
    int       tab_tail [ROWS] = '{32, 16, 8, 24};
    int       tab_num  [ROWS] = '{2, 3, 1, 0};
    int       tab_gap  [ROWS] = '{5, 9, 3, 2};
    int       tab_intr [ROWS] = '{3, 5, 2, 1};
    bit       tab_fill [ROWS] = '{0, 0, 1, 0};

    logic [31:0] lfsr = 32'h9839a846;
    logic [63:0] dma_q [$];
    logic [15:0] line_q [$];
    logic [15:0] exp_txd [$];
    logic [1:0]  exp_k [$];
    bit          exp_irq [$];
    int          dma_idx = 0;
    bit          ready_seen = 1'b0;
    bit          feed_on;
    bit          chan;
    int          cycle_cnt = 0;
    int          cycle_limit;

    tlk2711_tx_top dut0 (
        .clk                  (clk),
        .i_soft_reset         (i_soft_reset),
        .i_tx_mode            (i_tx_mode),
        .i_tx_start           (i_tx_start),
        .i_tx_packet_body     (i_tx_packet_body),
        .i_tx_packet_tail     (i_tx_packet_tail),
        .i_tx_body_num        (i_tx_body_num),
        .i_tx_intr_width      (i_tx_intr_width),
        .i_backward_cycle_num (i_backward_cycle_num),
        .i_dma_rd_valid       (i_dma_rd_valid),
        .i_dma_rd_data        (i_dma_rd_data),
        .o_dma_rd_ready       (o_dma_rd_ready),
        .o_tx_interrupt       (o_tx_interrupt),
        .o_tx_status          (o_tx_status),
        .o_2711_txd           (o_2711_txd),
        .o_2711_tkmsb         (o_2711_tkmsb),
        .o_2711_tklsb         (o_2711_tklsb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the send did not finish within %0d cycles", cycle_limit);
            stop_with_failure();
        end
    end

    // dma source, a word is offered until the fifo takes it
    always @(negedge clk) begin
        if (feed_on && i_dma_rd_valid && ready_seen)
            dma_idx = dma_idx + 1;
        if (feed_on && dma_idx < dma_q.size()) begin
            i_dma_rd_valid <= 1'b1;
            i_dma_rd_data  <= dma_q[dma_idx];
        end else
            i_dma_rd_valid <= 1'b0;
        ready_seen = o_dma_rd_ready;
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic int cycle_budget();
        int r;
        int total;
        total = 1000;
        for (r = 0; r < ROWS; r++)
            total += (tab_num[r] + 1) * (tab_body[r] / 2 + 20 + `TX_NORM_GAP + tab_gap[r])
                     + tab_intr[r] + 100;
        return total;
    endfunction

    task automatic load_dma(input int bytes);
        logic [63:0] w;
        int          n;
        int          b;
        for (n = 0; n < bytes / 8; n++) begin
            for (b = 0; b < 64; b++) begin
                w[b] = lfsr[0];
                lfsr = lfsr_step(lfsr);
            end
            dma_q.push_back(w);
            // low lane first
            for (b = 0; b < 4; b++)
                line_q.push_back(w[16 * b +: 16]);
        end
    endtask

    task automatic push_word(input logic [15:0] w, input logic [1:0] k, input bit irq);
        exp_txd.push_back(w);
        exp_k.push_back(k);
        exp_irq.push_back(irq);
    endtask

    //////////////////////////////
    // frame model
    //////////////////////////////
    task automatic build_expected(input int r);
        int          f;
        int          j;
        int          len;
        int          gap;
        bit          last;
        logic [15:0] sum;
        logic [15:0] sign;
        logic [23:0] fnum;
        logic [15:0] w;
        exp_txd.delete();
        exp_k.delete();
        exp_irq.delete();
        gap = (tab_mode[r] == SPECIFIC) ? tab_gap[r] : `TX_NORM_GAP;
        for (f = 0; f <= tab_num[r]; f++) begin
            last = (f == tab_num[r]);
            len  = last ? tab_tail[r] : tab_body[r];
            fnum = 24'(f);
            push_word(`TX_SOF_WORD, 2'b11, 1'b0);
            push_word(`TX_HEAD0, 2'b00, 1'b0);
            push_word(`TX_HEAD1, 2'b00, 1'b0);
            if (tab_mode[r] == SPECIFIC) begin
                // reserved, last, reserved, channel, sweep 1, frame bits 23 to 16
                sign = {1'b0, last, 1'b0, chan, 4'h1, fnum[23:16]};
                chan = !chan;
            end else
                sign = {`TX_IND, 7'd0, last};
            push_word(sign, 2'b00, 1'b0);
            push_word(fnum[15:0], 2'b00, 1'b0);
            push_word(16'(len), 2'b00, 1'b0);
            sum = fnum[15:0] + 16'(len);
            for (j = 0; j < len / 2; j++) begin
                w = line_q.pop_front();
                push_word(w, 2'b00, 1'b0);
                sum = sum + w;
            end
            push_word(sum, 2'b00, 1'b0);
            push_word(`TX_EOF_WORD, 2'b11, 1'b0);
            repeat (gap) push_word(`TX_IDLE_WORD, 2'b01, 1'b0);
        end
        repeat (tab_intr[r]) push_word(`TX_IDLE_WORD, 2'b01, 1'b1);
        repeat (4) push_word(`TX_IDLE_WORD, 2'b01, 1'b0);
    endtask

    task automatic wait_sof();
        while (!(o_2711_txd == `TX_SOF_WORD && o_2711_tkmsb && o_2711_tklsb))
            @(negedge clk);
    endtask

    // interrupt leads the line word by one cycle
    task automatic check_stream();
        int i;
        for (i = 0; i < exp_txd.size() - 1; i++) begin
            if (i > 0)
                @(negedge clk);
            assert (o_2711_txd == exp_txd[i]) else begin
                $display("Error: o_2711_txd word %0d expected %h got %h",
                         i, exp_txd[i], o_2711_txd);
                stop_with_failure();
            end
            assert ({o_2711_tkmsb, o_2711_tklsb} == exp_k[i]) else begin
                $display("Error: o_2711_tkmsb,o_2711_tklsb word %0d expected %h got %h",
                         i, exp_k[i], {o_2711_tkmsb, o_2711_tklsb});
                stop_with_failure();
            end
            assert (o_tx_interrupt == exp_irq[i + 1]) else begin
                $display("Error: o_tx_interrupt word %0d expected %h got %h",
                         i, exp_irq[i + 1], o_tx_interrupt);
                stop_with_failure();
            end
        end
    endtask

    task automatic pulse_start();
        i_tx_start <= 1'b1;
        @(negedge clk);
        i_tx_start <= 1'b0;
    endtask

    task automatic run_row(input int r);
        int fill_to;
        @(posedge clk);
        // fifo holds this many dma words when full
        fill_to = dma_q.size() + `TX_FIFO_DEPTH;
        load_dma(tab_num[r] * tab_body[r] + tab_tail[r]);
        build_expected(r);
        feed_on = 1'b1;
        @(negedge clk);
        i_tx_mode            <= tab_mode[r];
        i_tx_packet_body     <= 16'(tab_body[r]);
        i_tx_packet_tail     <= 16'(tab_tail[r]);
        i_tx_body_num        <= 24'(tab_num[r]);
        i_backward_cycle_num <= 20'(tab_gap[r]);
        i_tx_intr_width      <= 16'(tab_intr[r]);
        if (tab_fill[r]) begin
            while (dma_idx < fill_to)
                @(negedge clk);
            assert (!o_dma_rd_ready) else begin
                $display("Error: o_dma_rd_ready expected 0 got %h", o_dma_rd_ready);
                stop_with_failure();
            end
        end
        pulse_start();
        wait_sof();
        check_stream();
        assert (dma_idx == dma_q.size()) else begin
            $display("DMA words were not all taken, %0d left", dma_q.size() - dma_idx);
            stop_with_failure();
        end
    endtask

    task automatic check_reset_outputs();
        assert (o_2711_txd == `TX_IDLE_WORD) else begin
            $display("Error: o_2711_txd expected %h got %h", `TX_IDLE_WORD, o_2711_txd);
            stop_with_failure();
        end
        assert ({o_2711_tkmsb, o_2711_tklsb} == 2'b01) else begin
            $display("Error: o_2711_tkmsb,o_2711_tklsb expected 1 got %h",
                     {o_2711_tkmsb, o_2711_tklsb});
            stop_with_failure();
        end
        // empty, not full, IDLE, NORM
        assert (o_tx_status == 9'h100) else begin
            $display("Error: o_tx_status expected 100 got %h", o_tx_status);
            stop_with_failure();
        end
    endtask

    task automatic reset_mid_frame();
        @(posedge clk);
        load_dma(3 * 64);
        line_q.delete();
        feed_on = 1'b1;
        @(negedge clk);
        i_tx_mode        <= SPECIFIC;
        i_tx_packet_body <= 16'd64;
        i_tx_packet_tail <= 16'd64;
        i_tx_body_num    <= 24'd2;
        pulse_start();
        wait_sof();
        // well inside the data words
        repeat (12) @(negedge clk);
        @(posedge clk);
        feed_on = 1'b0;
        @(negedge clk);
        i_soft_reset <= 1'b1;
        repeat (2) @(negedge clk);
        check_reset_outputs();
        i_soft_reset <= 1'b0;
        @(negedge clk);
        check_reset_outputs();
    endtask

    initial begin
        int r;
        i_soft_reset         = 1'b1;
        i_tx_mode            = '0;
        i_tx_start           = 1'b0;
        i_tx_packet_body     = '0;
        i_tx_packet_tail     = '0;
        i_tx_body_num        = '0;
        i_tx_intr_width      = '0;
        i_backward_cycle_num = '0;
        feed_on              = 1'b0;
        chan                 = 1'b0;
        cycle_limit          = cycle_budget();
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_soft_reset <= 1'b0;
        for (r = 0; r < ROWS; r++)
            run_row(r);
        reset_mid_frame();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/tlk2711_tx_pkg.sv
rtl/tx_width_fifo.sv
rtl/frame_sequencer.sv
rtl/tx_word_encoder.sv
rtl/tlk2711_tx_top.sv
test/tlk2711_tx_chk.sv
test/tb_tlk2711_tx.sv
